// File: list.f
+incdir+.
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart.sv
uart_top.sv
uart_props.sv
uart_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the dual UART testbench with Verilator

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module uart_tb -o uart_sim \
    && ./obj_dir/uart_sim 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log && exit 1 \
    || grep -q "ALL TESTS PASSED" sim.log \
    || exit 1

// File: uart.sv
`default_nettype none

module uart (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  uart_pkg::uart_addr_t addr_i,
    input  uart_pkg::uart_word_t wdata_i,
    output uart_pkg::uart_word_t rdata_o,
    output logic                 ack_o,
    output logic                 irq_o,
    input  logic                 rxd_i,
    output logic                 txd_o
);
    import uart_pkg::*;

    logic       tx_start;
    uart_data_t tx_data;
    uart_div_t  div;
    logic       tx_busy;
    uart_data_t rx_data;
    logic       rx_valid;

    // Receive side
    uart_rx rx_module (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rxd_i      (rxd_i),
        .div_i      (div),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    uart_regs regs_module (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .rdata_o    (rdata_o),
        .ack_o      (ack_o),
        .tx_start_o (tx_start),
        .tx_data_o  (tx_data),
        .div_o      (div),
        .tx_busy_i  (tx_busy),
        .rx_data_i  (rx_data),
        .rx_valid_i (rx_valid),
        .irq_o      (irq_o)
    );

    // Transmit side
    uart_tx tx_module (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (tx_start),
        .tx_data_i (tx_data),
        .div_i     (div),
        .txd_o     (txd_o),
        .tx_busy_o (tx_busy)
    );

endmodule

`default_nettype wire

// File: uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Register indices on the bus
`define UART_REG_TXDATA 2'd0
`define UART_REG_RXDATA 2'd1
`define UART_REG_STATUS 2'd2
`define UART_REG_CTRL   2'd3

// Baud divisor in clocks per bit
`define UART_DEFAULT_DIV 16'd16
`define UART_MIN_DIV     16'd4

// Status register bits
`define UART_ST_TXBUSY  0
`define UART_ST_RXVALID 1
`define UART_ST_OVERRUN 2

// Control register layout, divisor sits in bits DIV_MSB:0
`define UART_CTRL_DIV_MSB 15
`define UART_CTRL_RXIE    16
`define UART_CTRL_TXIE    17

`endif

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Serial byte on the line
    typedef logic [7:0]  uart_data_t;
    // Bus write and read data
    typedef logic [31:0] uart_word_t;
    // Register index
    typedef logic [1:0]  uart_addr_t;
    // Clocks per bit
    typedef logic [15:0] uart_div_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

// File: uart_props.sv
`default_nettype none

module uart_props (
    input logic       clk,
    input logic       rst_n_i,
    input logic       uart0_sel_i,
    input logic       uart1_sel_i,
    input logic       dbus_req_i,
    input logic       dbus_ack_i,
    input logic [1:0] uart_txd_i,
    input logic       uart_irq_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Selected request is answered on the next edge
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        dbus_req_i && (uart0_sel_i || uart1_sel_i) |=> dbus_ack_i)
    else begin
        fail_count++;
        $error("ack missing one cycle after a selected request");
    end

    ack_only_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        dbus_ack_i |-> $past(dbus_req_i))
    else begin
        fail_count++;
        $error("ack without a request in the cycle before");
    end

    ack_needs_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        dbus_ack_i |-> (uart0_sel_i || uart1_sel_i))
    else begin
        fail_count++;
        $error("ack seen with no channel selected");
    end

    // Lines idle and interrupt quiet while in reset
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> (uart_txd_i == 2'b11 && !uart_irq_i))
    else begin
        fail_count++;
        $error("txd low or interrupt high during reset");
    end

endmodule

bind uart_top uart_props props_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .uart0_sel_i (uart0_sel_i),
    .uart1_sel_i (uart1_sel_i),
    .dbus_req_i  (dbus_req_i),
    .dbus_ack_i  (dbus_ack_o),
    .uart_txd_i  (uart_txd_o),
    .uart_irq_i  (uart_irq_o)
);

`default_nettype wire

// File: uart_regs.sv
`default_nettype none

`include "uart_macros.svh"

module uart_regs (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  uart_pkg::uart_addr_t addr_i,
    input  uart_pkg::uart_word_t wdata_i,
    output uart_pkg::uart_word_t rdata_o,
    output logic                 ack_o,
    output logic                 tx_start_o,
    output uart_pkg::uart_data_t tx_data_o,
    output uart_pkg::uart_div_t  div_o,
    input  logic                 tx_busy_i,
    input  uart_pkg::uart_data_t rx_data_i,
    input  logic                 rx_valid_i,
    output logic                 irq_o
);
    import uart_pkg::*;

    uart_div_t  div_q;
    logic       rx_ie_q;
    logic       tx_ie_q;
    uart_data_t rx_data_q;
    logic       rx_valid_q;
    logic       overrun_q;
    uart_word_t rdata_q;
    logic       ack_q;
    logic       wr;
    logic       rd_rx;
    uart_div_t  wr_div;
    uart_word_t rd_mux;

    assign wr     = req_i && we_i;
    assign rd_rx  = req_i && !we_i && (addr_i == `UART_REG_RXDATA);
    assign wr_div = (wdata_i[`UART_CTRL_DIV_MSB:0] < `UART_MIN_DIV) ?
                    `UART_MIN_DIV : wdata_i[`UART_CTRL_DIV_MSB:0];

    // Writes to a busy transmitter are dropped here
    assign tx_start_o = wr && (addr_i == `UART_REG_TXDATA) && !tx_busy_i;
    assign tx_data_o  = wdata_i[7:0];
    assign div_o      = div_q;

    assign irq_o = (rx_valid_q && rx_ie_q) || (!tx_busy_i && tx_ie_q);

    always_comb begin
        rd_mux = '0;
        case (addr_i)
            `UART_REG_RXDATA: rd_mux[7:0] = rx_data_q;
            `UART_REG_STATUS: begin
                rd_mux[`UART_ST_TXBUSY]  = tx_busy_i;
                rd_mux[`UART_ST_RXVALID] = rx_valid_q;
                rd_mux[`UART_ST_OVERRUN] = overrun_q;
            end
            `UART_REG_CTRL: begin
                rd_mux[`UART_CTRL_DIV_MSB:0] = div_q;
                rd_mux[`UART_CTRL_RXIE]      = rx_ie_q;
                rd_mux[`UART_CTRL_TXIE]      = tx_ie_q;
            end
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q      <= `UART_DEFAULT_DIV;
            rx_ie_q    <= 1'b0;
            tx_ie_q    <= 1'b0;
            rx_valid_q <= 1'b0;
            overrun_q  <= 1'b0;
            rdata_q    <= '0;
            ack_q      <= 1'b0;
        end else begin
            ack_q   <= req_i;
            rdata_q <= (req_i && !we_i) ? rd_mux : '0;
            if (wr && addr_i == `UART_REG_CTRL) begin
                div_q   <= wr_div;
                rx_ie_q <= wdata_i[`UART_CTRL_RXIE];
                tx_ie_q <= wdata_i[`UART_CTRL_TXIE];
            end
            // New byte wins over a read in the same cycle
            if (rx_valid_i) begin
                rx_valid_q <= 1'b1;
                overrun_q  <= !rd_rx && (overrun_q || rx_valid_q);
            end else if (rd_rx) begin
                rx_valid_q <= 1'b0;
                overrun_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            rx_data_q <= rx_data_i;
        end
    end

    assign rdata_o = rdata_q;
    assign ack_o   = ack_q;

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 rxd_i,
    input  uart_pkg::uart_div_t  div_i,
    output uart_pkg::uart_data_t rx_data_o,
    output logic                 rx_valid_o
);
    import uart_pkg::*;

    rx_state_t  state_q;
    logic [1:0] sync_q;
    logic       rxd_prev_q;
    uart_div_t  baud_cnt_q;
    logic [2:0] bit_cnt_q;
    uart_data_t shift_q;
    logic       valid_q;
    logic       rxd_s;
    logic       half_end;
    logic       bit_end;

    assign rxd_s    = sync_q[1];
    // Start bit is checked half a bit after the falling edge
    assign half_end = (baud_cnt_q == (div_i >> 1) - 16'd1);
    assign bit_end  = (baud_cnt_q == div_i - 16'd1);

    assign rx_data_o  = shift_q;
    assign rx_valid_o = valid_q;

    // Line idles high, so the synchroniser comes out of reset at 1
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q     <= 2'b11;
            rxd_prev_q <= 1'b1;
        end else begin
            sync_q     <= {sync_q[0], rxd_i};
            rxd_prev_q <= rxd_s;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= RX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q    <= 1'b0;
            baud_cnt_q <= baud_cnt_q + 16'd1;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (rxd_prev_q && !rxd_s) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= '0;
                        // Glitch that went high again by mid-bit is dropped
                        state_q    <= rxd_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state_q <= RX_IDLE;
                        // Bad stop bit just loses the byte
                        valid_q <= rxd_s;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && bit_end) begin
            shift_q <= {rxd_s, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: uart_tb.sv
`default_nettype none

`include "uart_macros.svh"

module uart_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;

    localparam int CLK_PERIOD_NS = 20;
    localparam int FRAME_COUNT   = 7;
    localparam int MAX_DIV       = 16;
    localparam int WATCHDOG_NS   = FRAME_COUNT * 10 * MAX_DIV * CLK_PERIOD_NS * 3;
    localparam int ACK_LIMIT     = 4;
    localparam int POLL_LIMIT    = 200;
    localparam int IRQ_LIMIT     = 400;

    localparam logic [1:0] SEL_NONE = 2'b00;
    localparam logic [1:0] SEL_CH0  = 2'b01;
    localparam logic [1:0] SEL_CH1  = 2'b10;
    localparam logic [1:0] SEL_BOTH = 2'b11;

    logic       clk;
    logic       rst_n;
    logic       uart0_sel;
    logic       uart1_sel;
    logic       dbus_req;
    logic       dbus_we;
    uart_addr_t dbus_addr;
    uart_word_t dbus_wdata;
    uart_word_t dbus_rdata;
    logic       dbus_ack;
    logic       uart_irq;
    logic [1:0] uart_rxd;
    logic [1:0] uart_txd;

    int errors;
    int tests_run;
    int tests_failed;
    int errors_before;

    // Lines cross over so each channel hears the other
    assign uart_rxd = {uart_txd[0], uart_txd[1]};

    uart_top dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .uart0_sel_i  (uart0_sel),
        .uart1_sel_i  (uart1_sel),
        .dbus_req_i   (dbus_req),
        .dbus_we_i    (dbus_we),
        .dbus_addr_i  (dbus_addr),
        .dbus_wdata_i (dbus_wdata),
        .dbus_rdata_o (dbus_rdata),
        .dbus_ack_o   (dbus_ack),
        .uart_irq_o   (uart_irq),
        .uart_rxd_i   (uart_rxd),
        .uart_txd_o   (uart_txd)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, actual, expected);
            errors++;
        end
    endtask

    // One request strobe and a wait for the ack with the select held
    task automatic bus_access(input logic [1:0] sel, input logic we, input uart_addr_t addr,
                              input uart_word_t wdata, output uart_word_t rdata,
                              output logic acked);
        int waited;
        @(negedge clk);
        uart0_sel  = sel[0];
        uart1_sel  = sel[1];
        dbus_req   = 1'b1;
        dbus_we    = we;
        dbus_addr  = addr;
        dbus_wdata = wdata;
        @(negedge clk);
        dbus_req = 1'b0;
        dbus_we  = 1'b0;
        waited   = 0;
        acked    = 1'b0;
        rdata    = dbus_rdata;
        while (!acked && waited < ACK_LIMIT) begin
            if (dbus_ack) begin
                acked = 1'b1;
                rdata = dbus_rdata;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        // Ack has dropped by the next falling edge
        @(negedge clk);
        uart0_sel = 1'b0;
        uart1_sel = 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] sel, input uart_addr_t addr,
                             input uart_word_t data);
        uart_word_t unused;
        logic       acked;
        bus_access(sel, 1'b1, addr, data, unused, acked);
        if (!acked) begin
            $display("no ack for a write to register %0d", addr);
            errors++;
        end
    endtask

    task automatic bus_read(input logic [1:0] sel, input uart_addr_t addr,
                            output uart_word_t data);
        logic acked;
        bus_access(sel, 1'b0, addr, '0, data, acked);
        if (!acked) begin
            $display("no ack for a read of register %0d", addr);
            errors++;
        end
    endtask

    task automatic wait_status(input logic [1:0] sel, input int bit_pos, input logic value,
                               input string what);
        uart_word_t st;
        int         polls;
        polls = 0;
        bus_read(sel, `UART_REG_STATUS, st);
        while (st[bit_pos] !== value && polls < POLL_LIMIT) begin
            bus_read(sel, `UART_REG_STATUS, st);
            polls++;
        end
        if (st[bit_pos] !== value) begin
            $display("timed out waiting for %s", what);
            errors++;
        end
    endtask

    task automatic wait_irq(input logic value, input string what);
        int cycles;
        cycles = 0;
        while (uart_irq !== value && cycles < IRQ_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (uart_irq !== value) begin
            $display("timed out waiting for %s", what);
            errors++;
        end
    endtask

    task automatic set_div_both(input logic [15:0] div);
        bus_write(SEL_CH0, `UART_REG_CTRL, {16'd0, div});
        bus_write(SEL_CH1, `UART_REG_CTRL, {16'd0, div});
    endtask

    task automatic send_and_receive(input logic [1:0] src, input logic [1:0] dst,
                                    input uart_data_t data);
        uart_word_t rd;
        bus_write(src, `UART_REG_TXDATA, {24'd0, data});
        wait_status(dst, `UART_ST_RXVALID, 1'b1, "rx valid");
        bus_read(dst, `UART_REG_RXDATA, rd);
        check("rxdata", rd, {24'd0, data});
        bus_read(dst, `UART_REG_STATUS, rd);
        check("status", rd, 32'd0);
        wait_status(src, `UART_ST_TXBUSY, 1'b0, "transmitter idle");
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
        errors_before = errors;
    endtask

    task automatic reset_values();
        uart_word_t rd;
        bus_read(SEL_CH0, `UART_REG_STATUS, rd);
        check("status ch0", rd, 32'd0);
        bus_read(SEL_CH1, `UART_REG_STATUS, rd);
        check("status ch1", rd, 32'd0);
        bus_read(SEL_CH0, `UART_REG_CTRL, rd);
        check("ctrl ch0", rd, {16'd0, `UART_DEFAULT_DIV});
        bus_read(SEL_CH1, `UART_REG_CTRL, rd);
        check("ctrl ch1", rd, {16'd0, `UART_DEFAULT_DIV});
        check("uart_txd_o", 32'(uart_txd), 32'd3);
        check("uart_irq_o", 32'(uart_irq), 32'd0);
    endtask

    task automatic transfer_at_div(input logic [15:0] div, input logic [15:0] expected_div);
        uart_word_t rd;
        set_div_both(div);
        bus_read(SEL_CH0, `UART_REG_CTRL, rd);
        check("ctrl ch0", rd, {16'd0, expected_div});
        bus_read(SEL_CH1, `UART_REG_CTRL, rd);
        check("ctrl ch1", rd, {16'd0, expected_div});
        send_and_receive(SEL_CH0, SEL_CH1, 8'($urandom));
    endtask

    task automatic ch0_to_ch1_transfer();
        transfer_at_div(`UART_DEFAULT_DIV, `UART_DEFAULT_DIV);
        transfer_at_div(16'd8, 16'd8);
        // Below the minimum, so the divisor reads back as the minimum
        transfer_at_div(16'd2, `UART_MIN_DIV);
        set_div_both(`UART_DEFAULT_DIV);
    endtask

    task automatic receive_interrupt();
        uart_word_t rd;
        uart_data_t data;
        data = 8'($urandom);
        bus_write(SEL_CH0, `UART_REG_CTRL,
                  (32'd1 << `UART_CTRL_RXIE) | {16'd0, `UART_DEFAULT_DIV});
        check("uart_irq_o", 32'(uart_irq), 32'd0);
        bus_write(SEL_CH1, `UART_REG_TXDATA, {24'd0, data});
        wait_irq(1'b1, "the receive interrupt");
        bus_read(SEL_CH0, `UART_REG_STATUS, rd);
        check("status ch0", rd, 32'd1 << `UART_ST_RXVALID);
        bus_read(SEL_CH0, `UART_REG_RXDATA, rd);
        check("rxdata ch0", rd, {24'd0, data});
        check("uart_irq_o", 32'(uart_irq), 32'd0);
        bus_write(SEL_CH0, `UART_REG_CTRL, {16'd0, `UART_DEFAULT_DIV});
        wait_status(SEL_CH1, `UART_ST_TXBUSY, 1'b0, "transmitter idle on channel 1");
    endtask

    task automatic select_steering();
        uart_word_t rd;
        logic       acked;
        bus_write(SEL_BOTH, `UART_REG_CTRL, 32'd9);
        bus_read(SEL_CH0, `UART_REG_CTRL, rd);
        check("ctrl ch0", rd, 32'd9);
        bus_read(SEL_CH1, `UART_REG_CTRL, rd);
        check("ctrl ch1", rd, {16'd0, `UART_DEFAULT_DIV});
        // CTRL is nonzero, so a leaked read would show
        bus_access(SEL_NONE, 1'b0, `UART_REG_CTRL, '0, rd, acked);
        check("dbus_ack_o", 32'(acked), 32'd0);
        check("dbus_rdata_o", rd, 32'd0);
        bus_write(SEL_CH0, `UART_REG_CTRL, {16'd0, `UART_DEFAULT_DIV});
    endtask

    task automatic overrun_and_busy_drop();
        uart_word_t rd;
        uart_data_t first;
        uart_data_t second;
        second = 8'($urandom);
        first  = second ^ 8'hff;
        bus_write(SEL_CH0, `UART_REG_TXDATA, {24'd0, first});
        wait_status(SEL_CH0, `UART_ST_TXBUSY, 1'b0, "transmitter idle");
        bus_write(SEL_CH0, `UART_REG_TXDATA, {24'd0, second});
        bus_read(SEL_CH0, `UART_REG_STATUS, rd);
        check("status ch0", rd, 32'd1 << `UART_ST_TXBUSY);
        bus_write(SEL_CH0, `UART_REG_TXDATA, {24'd0, ~second});
        wait_status(SEL_CH0, `UART_ST_TXBUSY, 1'b0, "transmitter idle");
        wait_status(SEL_CH1, `UART_ST_OVERRUN, 1'b1, "overrun");
        bus_read(SEL_CH1, `UART_REG_STATUS, rd);
        check("status ch1", rd, (32'd1 << `UART_ST_RXVALID) | (32'd1 << `UART_ST_OVERRUN));
        bus_read(SEL_CH1, `UART_REG_RXDATA, rd);
        check("rxdata ch1", rd, {24'd0, second});
        bus_read(SEL_CH1, `UART_REG_STATUS, rd);
        check("status ch1", rd, 32'd0);
    endtask

    task automatic tx_idle_interrupt();
        uart_word_t rd;
        uart_data_t data;
        data = 8'($urandom);
        bus_write(SEL_CH0, `UART_REG_CTRL,
                  (32'd1 << `UART_CTRL_TXIE) | {16'd0, `UART_DEFAULT_DIV});
        check("uart_irq_o", 32'(uart_irq), 32'd1);
        bus_write(SEL_CH0, `UART_REG_TXDATA, {24'd0, data});
        check("uart_irq_o", 32'(uart_irq), 32'd0);
        // Halfway through the frame
        repeat (5 * MAX_DIV) @(negedge clk);
        check("uart_irq_o", 32'(uart_irq), 32'd0);
        wait_irq(1'b1, "the transmit idle interrupt");
        wait_status(SEL_CH1, `UART_ST_RXVALID, 1'b1, "rx valid on channel 1");
        bus_read(SEL_CH1, `UART_REG_RXDATA, rd);
        check("rxdata ch1", rd, {24'd0, data});
        bus_write(SEL_CH0, `UART_REG_CTRL, {16'd0, `UART_DEFAULT_DIV});
        check("uart_irq_o", 32'(uart_irq), 32'd0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        rst_n         = 1'b1;
        uart0_sel     = 1'b0;
        uart1_sel     = 1'b0;
        dbus_req      = 1'b0;
        dbus_we       = 1'b0;
        dbus_addr     = '0;
        dbus_wdata    = '0;
        void'($urandom(32'hffd65040));
        #1 rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        report_test("reset values");
        ch0_to_ch1_transfer();
        report_test("channel 0 to channel 1");
        receive_interrupt();
        report_test("receive interrupt");
        select_steering();
        report_test("select steering");
        overrun_and_busy_drop();
        report_test("overrun and busy drop");
        tx_idle_interrupt();
        report_test("transmit idle interrupt");

        if (dut.props_inst.fail_count != 0) begin
            $display("%0d assertion failures at the top level", dut.props_inst.fail_count);
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_top.sv
`default_nettype none

module uart_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 uart0_sel_i,
    input  logic                 uart1_sel_i,
    input  logic                 dbus_req_i,
    input  logic                 dbus_we_i,
    input  uart_pkg::uart_addr_t dbus_addr_i,
    input  uart_pkg::uart_word_t dbus_wdata_i,
    output uart_pkg::uart_word_t dbus_rdata_o,
    output logic                 dbus_ack_o,
    output logic                 uart_irq_o,
    input  logic [1:0]           uart_rxd_i,
    output logic [1:0]           uart_txd_o
);
    import uart_pkg::*;

    logic       uart0_req;
    logic       uart1_req;
    uart_word_t uart0_rdata;
    uart_word_t uart1_rdata;
    logic       uart0_ack;
    logic       uart1_ack;
    logic       uart0_irq;
    logic       uart1_irq;
    logic       uart0_txd;
    logic       uart1_txd;

    assign uart_irq_o = uart0_irq | uart1_irq;
    assign uart_txd_o = {uart1_txd, uart0_txd};

    // Channel 0 wins when both selects are high
    always_comb begin
        uart0_req    = 1'b0;
        uart1_req    = 1'b0;
        dbus_rdata_o = '0;
        dbus_ack_o   = 1'b0;
        if (uart0_sel_i) begin
            uart0_req    = dbus_req_i;
            dbus_rdata_o = uart0_rdata;
            dbus_ack_o   = uart0_ack;
        end else if (uart1_sel_i) begin
            uart1_req    = dbus_req_i;
            dbus_rdata_o = uart1_rdata;
            dbus_ack_o   = uart1_ack;
        end
    end

    uart uart0_module (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (uart0_req),
        .we_i    (dbus_we_i),
        .addr_i  (dbus_addr_i),
        .wdata_i (dbus_wdata_i),
        .rdata_o (uart0_rdata),
        .ack_o   (uart0_ack),
        .irq_o   (uart0_irq),
        .rxd_i   (uart_rxd_i[0]),
        .txd_o   (uart0_txd)
    );

    uart uart1_module (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (uart1_req),
        .we_i    (dbus_we_i),
        .addr_i  (dbus_addr_i),
        .wdata_i (dbus_wdata_i),
        .rdata_o (uart1_rdata),
        .ack_o   (uart1_ack),
        .irq_o   (uart1_irq),
        .rxd_i   (uart_rxd_i[1]),
        .txd_o   (uart1_txd)
    );

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  uart_pkg::uart_data_t tx_data_i,
    input  uart_pkg::uart_div_t  div_i,
    output logic                 txd_o,
    output logic                 tx_busy_o
);
    import uart_pkg::*;

    tx_state_t  state_q;
    uart_div_t  baud_cnt_q;
    logic [2:0] bit_cnt_q;
    uart_data_t shift_q;
    logic       txd_q;
    logic       bit_end;

    assign bit_end   = (baud_cnt_q == div_i - 16'd1);
    assign txd_o     = txd_q;
    assign tx_busy_o = (state_q != TX_IDLE);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            txd_q      <= 1'b1;
        end else begin
            baud_cnt_q <= bit_end ? '0 : baud_cnt_q + 16'd1;
            case (state_q)
                TX_IDLE: begin
                    baud_cnt_q <= '0;
                    // Start bit goes out together with busy
                    if (start_i) begin
                        state_q <= TX_START;
                        txd_q   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                        txd_q     <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= TX_STOP;
                            txd_q   <= 1'b1;
                        end else begin
                            txd_q <= shift_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Bit 0 is always the one on the line during the data phase
    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && start_i) begin
            shift_q <= tx_data_i;
        end else if (state_q == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire
